/* noc_pkg.sv */
package noc_pkg;

	// router geometry
	localparam int VC_NUM       = 4;  // virtual channels per port
	localparam int PORT_SEL_NUM = 4;  // every port except our own
	localparam int PYLD_WIDTH   = 32; // flit payload bits

	// binary index widths
	localparam int VC_ID_W    = $clog2(VC_NUM);
	localparam int PORT_SEL_W = $clog2(PORT_SEL_NUM);

	// one bit per vc, used for flit vc field, requests, grants, credits
	typedef logic [VC_NUM-1:0] vc_onehot_t;

	// output vc number
	typedef logic [VC_ID_W-1:0] vc_id_t;

	// output port select, binary
	typedef logic [PORT_SEL_W-1:0] port_sel_t;

	// 38-bit flit, msb first
	// header flits carry the output port select in pyld[1:0]
	typedef struct packed {
		logic                  hdr;  // first flit of packet
		logic                  tail; // last flit of packet
		vc_onehot_t            vc;   // one-hot input vc
		logic [PYLD_WIDTH-1:0] pyld;
	} flit_t;

	// one bit per (output port, output vc) pair
	// bit index is port * VC_NUM + vc
	typedef logic [PORT_SEL_NUM*VC_NUM-1:0] ovc_vec_t;

	// header port field location inside the payload
	localparam int HDR_PORT_LSB = 0;

endpackage

/* vc_fifo.sv */
module vc_fifo #(
	parameter int  DEPTH = 4,     // entries
	parameter type T     = logic  // payload type
) (
	input  logic clk,
	input  logic reset,
	input  T     din,
	input  logic wr_en,
	input  logic rd_en,
	output T     dout,      // head, valid while not_empty
	output logic not_empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH]; // circular store

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // occupancy
	logic             push;
	logic             pop;

	// wrap at DEPTH-1, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign push = wr_en && (count != CNT_W'(DEPTH)); // full drops the write
	assign pop  = rd_en && not_empty;                // read on empty ignored

	assign not_empty = (count != '0);
	assign dout      = mem[rd_ptr]; // first word fall through

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle or push and pop together
			endcase
		end
	end

endmodule

/* input_flit_buffer.sv */
module input_flit_buffer
	import noc_pkg::*;
#(
	parameter int BUF_DEPTH = 4 // flits per vc
) (
	input  logic       clk,
	input  logic       reset,
	input  flit_t      flit_in,
	input  logic       wr_in_en,
	input  vc_onehot_t ivc_granted,        // one-hot or zero
	output flit_t      head_flit [VC_NUM], // per-vc head, zero latency
	output vc_onehot_t vc_not_empty
);

	vc_onehot_t vc_wr; // write steer, one bit per vc
	vc_onehot_t vc_rd; // pop, one bit per vc

	// the flit's own vc field picks the fifo
	assign vc_wr = flit_in.vc & {VC_NUM{wr_in_en}};

	// granted vc gives up its head this edge
	assign vc_rd = ivc_granted;

	genvar i;
	generate
		for (i = 0; i < VC_NUM; i++) begin : g_vc
			// credit flow control upstream keeps this from ever filling
			vc_fifo #(
				.DEPTH (BUF_DEPTH),
				.T     (flit_t)
			) u_flit_fifo (
				.clk       (clk),
				.reset     (reset),
				.din       (flit_in),
				.wr_en     (vc_wr[i]),
				.rd_en     (vc_rd[i]),
				.dout      (head_flit[i]),
				.not_empty (vc_not_empty[i])
			);
		end
	endgenerate

endmodule

/* vc_route_state.sv */
module vc_route_state
	import noc_pkg::*;
#(
	parameter int PKT_DEPTH = 2, // packets queued per vc
	parameter int VC_ID     = 0  // which vc this instance serves
) (
	input  logic                    clk,
	input  logic                    reset,

	// upstream write side, shared by all vcs
	input  flit_t                   flit_in,
	input  logic                    wr_in_en,

	// this vc's buffer head
	input  flit_t                   head_flit,
	input  logic                    not_empty,

	// from switch allocator
	input  logic                    granted,

	// from ovc status unit
	input  vc_id_t                  candidate_ovcs [PORT_SEL_NUM],
	input  logic [PORT_SEL_NUM-1:0] ovc_available,

	// to allocator, output stage
	output logic                    request,
	output port_sel_t               out_port,   // port of the head packet
	output vc_id_t                  ovc,        // ovc the head flit will use
	output logic                    ovc_alloc,  // grant takes a new ovc
	output logic                    ovc_release // grant frees the ovc
);

	logic      rq_wr;       // header arriving on this vc
	logic      rq_rd;       // tail leaving this vc
	port_sel_t hdr_port;    // port field of incoming flit
	logic      rq_nempty;   // route queue holds a packet
	logic      assigned;    // holds an output vc
	vc_id_t    ovc_q;       // the output vc it holds
	vc_id_t    cand_ovc;    // offer for the head packet's port
	logic      port_avail;  // some ovc free at that port
	logic      take_ovc;    // grant while unassigned
	logic      tail_passed; // grant on a tail flit

	assign hdr_port = flit_in.pyld[HDR_PORT_LSB +: PORT_SEL_W];

	// one entry per header, popped with the packet's tail
	assign rq_wr = wr_in_en & flit_in.vc[VC_ID] & flit_in.hdr;
	assign rq_rd = tail_passed;

	vc_fifo #(
		.DEPTH (PKT_DEPTH),
		.T     (port_sel_t)
	) u_route_q (
		.clk       (clk),
		.reset     (reset),
		.din       (hdr_port),
		.wr_en     (rq_wr),
		.rd_en     (rq_rd),
		.dout      (out_port),
		.not_empty (rq_nempty)
	);

	assign cand_ovc   = candidate_ovcs[out_port];
	assign port_avail = ovc_available[out_port];

	assign take_ovc    = granted & ~assigned;
	assign tail_passed = granted & head_flit.tail;

	// unassigned heads ride on the current offer
	assign ovc = assigned ? ovc_q : cand_ovc;

	// a buffered flit always has its packet queued; rq_nempty only guards the lookup
	assign request = not_empty & rq_nempty & (assigned | port_avail);

	assign ovc_alloc   = take_ovc;
	assign ovc_release = tail_passed; // single flit packet raises both

	always_ff @(posedge clk) begin
		if (take_ovc)
			ovc_q <= cand_ovc; // latch the offer seen in the grant cycle
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			assigned <= 1'b0;
		end else begin
			if (take_ovc)
				assigned <= 1'b1;
			if (tail_passed)
				assigned <= 1'b0; // tail wins, covers single flit packets
		end
	end

endmodule

/* grant_output_stage.sv */
module grant_output_stage
	import noc_pkg::*;
(
	input  logic       clk,
	input  logic       reset,

	input  vc_onehot_t ivc_granted,         // one-hot or zero
	input  flit_t      head_flit [VC_NUM],
	input  port_sel_t  out_port  [VC_NUM],
	input  vc_id_t     ovc       [VC_NUM],
	input  vc_onehot_t ovc_alloc,           // per vc, already qualified by grant
	input  vc_onehot_t ovc_release,

	// crossbar side, valid the cycle after the grant
	output flit_t      flit_out,
	output logic       flit_out_valid,
	output port_sel_t  port_out,
	output vc_id_t     ovc_out,

	// upstream credit, ovc status pulses
	output vc_onehot_t credit_out,
	output ovc_vec_t   ovc_allocated,
	output ovc_vec_t   ovc_released
);

	flit_t     sel_flit;
	port_sel_t sel_port;
	vc_id_t    sel_ovc;
	logic      any_grant;
	ovc_vec_t  alloc_nxt;
	ovc_vec_t  release_nxt;

	assign any_grant = |ivc_granted;

	// mux toward the crossbar, grant is at most one-hot
	always_comb begin
		sel_flit = '0;
		sel_port = '0;
		sel_ovc  = '0;
		for (int i = 0; i < VC_NUM; i++) begin
			if (ivc_granted[i]) begin
				sel_flit = head_flit[i];
				sel_port = out_port[i];
				sel_ovc  = ovc[i];
			end
		end
	end

	// place each vc's pulse at its (port, ovc) slot
	always_comb begin
		int idx;
		alloc_nxt   = '0;
		release_nxt = '0;
		for (int i = 0; i < VC_NUM; i++) begin
			idx = int'(out_port[i]) * VC_NUM + int'(ovc[i]);
			if (ovc_alloc[i])
				alloc_nxt[idx] = 1'b1;
			if (ovc_release[i])
				release_nxt[idx] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (any_grant) begin // hold last flit otherwise
			flit_out <= sel_flit;
			port_out <= sel_port;
			ovc_out  <= sel_ovc;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flit_out_valid <= 1'b0;
			credit_out     <= '0;
			ovc_allocated  <= '0;
			ovc_released   <= '0;
		end else begin
			flit_out_valid <= any_grant;
			credit_out     <= ivc_granted; // one slot freed per grant
			ovc_allocated  <= alloc_nxt;
			ovc_released   <= release_nxt;
		end
	end

endmodule

/* input_port.sv */
module input_port
	import noc_pkg::*;
#(
	parameter int BUF_DEPTH = 4 // flits per vc
) (
	input  logic                    clk,
	input  logic                    reset,

	// neighbour router
	input  flit_t                   flit_in,
	input  logic                    wr_in_en,
	output vc_onehot_t              credit_out,

	// ovc status unit
	input  vc_id_t                  candidate_ovcs [PORT_SEL_NUM],
	input  logic [PORT_SEL_NUM-1:0] ovc_available,
	output ovc_vec_t                ovc_allocated,
	output ovc_vec_t                ovc_released,

	// switch allocator
	output vc_onehot_t              ivc_request,
	output port_sel_t               out_port_select [VC_NUM],
	input  vc_onehot_t              ivc_granted,

	// crossbar
	output flit_t                   flit_out,
	output logic                    flit_out_valid,
	output port_sel_t               port_out,
	output vc_id_t                  ovc_out
);

	localparam int PKT_CAP   = 4;
	localparam int PKT_DEPTH = (BUF_DEPTH / 2 > PKT_CAP) ? PKT_CAP : BUF_DEPTH / 2;

	flit_t      head_flit [VC_NUM]; // buffer heads
	vc_onehot_t vc_not_empty;
	vc_id_t     vc_ovc    [VC_NUM]; // ovc each head would use
	vc_onehot_t vc_alloc;
	vc_onehot_t vc_release;

	input_flit_buffer #(
		.BUF_DEPTH (BUF_DEPTH)
	) u_buffer (
		.clk          (clk),
		.reset        (reset),
		.flit_in      (flit_in),
		.wr_in_en     (wr_in_en),
		.ivc_granted  (ivc_granted),
		.head_flit    (head_flit),
		.vc_not_empty (vc_not_empty)
	);

	genvar i;
	generate
		for (i = 0; i < VC_NUM; i++) begin : g_vc
			vc_route_state #(
				.PKT_DEPTH (PKT_DEPTH),
				.VC_ID     (i)
			) u_route (
				.clk            (clk),
				.reset          (reset),
				.flit_in        (flit_in),
				.wr_in_en       (wr_in_en),
				.head_flit      (head_flit[i]),
				.not_empty      (vc_not_empty[i]),
				.granted        (ivc_granted[i]),
				.candidate_ovcs (candidate_ovcs),
				.ovc_available  (ovc_available),
				.request        (ivc_request[i]),
				.out_port       (out_port_select[i]),
				.ovc            (vc_ovc[i]),
				.ovc_alloc      (vc_alloc[i]),
				.ovc_release    (vc_release[i])
			);
		end
	endgenerate

	grant_output_stage u_out (
		.clk            (clk),
		.reset          (reset),
		.ivc_granted    (ivc_granted),
		.head_flit      (head_flit),
		.out_port       (out_port_select),
		.ovc            (vc_ovc),
		.ovc_alloc      (vc_alloc),
		.ovc_release    (vc_release),
		.flit_out       (flit_out),
		.flit_out_valid (flit_out_valid),
		.port_out       (port_out),
		.ovc_out        (ovc_out),
		.credit_out     (credit_out),
		.ovc_allocated  (ovc_allocated),
		.ovc_released   (ovc_released)
	);

endmodule

/* input_port_checker.sv */
module input_port_checker
	import noc_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input flit_t      flit_in,
	input logic       wr_in_en,
	input vc_onehot_t ivc_request,
	input vc_onehot_t ivc_granted,
	input logic       flit_out_valid,
	input vc_onehot_t credit_out
);

	// upstream names exactly one vc per flit
	a_write_onehot: assert property (@(posedge clk) disable iff (reset)
		wr_in_en |-> $onehot(flit_in.vc))
		else $error("flit written without exactly one vc bit");

	// allocator grants at most one requester
	a_grant_legal: assert property (@(posedge clk) disable iff (reset)
		$onehot0(ivc_granted) && ((ivc_granted & ~ivc_request) == '0))
		else $error("grant not one-hot or not requested");

	a_valid_follows_grant: assert property (@(posedge clk) disable iff (reset)
		flit_out_valid == $past(|ivc_granted))
		else $error("flit_out_valid does not follow last grant");

	a_credit_follows_grant: assert property (@(posedge clk) disable iff (reset)
		credit_out == $past(ivc_granted)) // one credit per popped flit
		else $error("credit_out does not match last grant");

endmodule

bind input_port input_port_checker u_checker (.*);

/* tb_input_port.sv */
module tb_input_port
	import noc_pkg::*;
();

	localparam int BUF_DEPTH = 4;
	localparam int PKT_DEPTH = (BUF_DEPTH / 2 > 4) ? 4 : BUF_DEPTH / 2; // route queue entries
	localparam int NUM_PKTS  = 300;
	localparam int MAX_FLITS = 4;
	localparam int LIMIT     = 16 + 8 * NUM_PKTS * MAX_FLITS; // cycles

	logic                    clk = 1'b0;
	logic                    reset;
	flit_t                   flit_in;
	logic                    wr_in_en;
	vc_onehot_t              credit_out;
	vc_id_t                  candidate_ovcs [PORT_SEL_NUM];
	logic [PORT_SEL_NUM-1:0] ovc_available;
	ovc_vec_t                ovc_allocated;
	ovc_vec_t                ovc_released;
	vc_onehot_t              ivc_request;
	port_sel_t               out_port_select [VC_NUM];
	vc_onehot_t              ivc_granted;
	flit_t                   flit_out;
	logic                    flit_out_valid;
	port_sel_t               port_out;
	vc_id_t                  ovc_out;

	// reference model state
	flit_t      fq [VC_NUM][$];    // flits held per vc
	port_sel_t  pq [VC_NUM][$];    // packet port of each held flit
	logic       assigned [VC_NUM];
	vc_id_t     held_ovc [VC_NUM];
	int         credits [VC_NUM];   // upstream credit count
	int         open_pkts [VC_NUM]; // headers sent, tail not yet granted
	int         left [VC_NUM];      // flits still to send of the open packet
	port_sel_t  wr_port [VC_NUM];
	int         pkts_sent;
	int         errors;
	int         cycle;
	logic       exp_valid;          // expected registered outputs
	flit_t      exp_flit;
	port_sel_t  exp_port;
	vc_id_t     exp_ovc;
	vc_onehot_t exp_credit;
	ovc_vec_t   exp_alloc;
	ovc_vec_t   exp_rel;
	logic       pend_wr;            // write the dut takes at the coming edge
	int         pend_vc;
	flit_t      pend_flit;
	port_sel_t  pend_port;

	input_port #(.BUF_DEPTH (BUF_DEPTH)) DUT (.*);

	always #50 clk = ~clk;

	task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act) else begin
			$display("Error %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	// vc non-empty and either holding an ovc or its head port has one free
	function automatic vc_onehot_t model_request();
		vc_onehot_t r;
		r = '0;
		for (int v = 0; v < VC_NUM; v++)
			if (fq[v].size() != 0)
				r[v] = assigned[v] | ovc_available[pq[v][0]];
		return r;
	endfunction

	// all packets sent and every model queue emptied by grants
	function automatic bit traffic_drained();
		bit d;
		d = (pkts_sent == NUM_PKTS) && !pend_wr;
		for (int v = 0; v < VC_NUM; v++)
			d &= (fq[v].size() == 0) && (left[v] == 0);
		return d;
	endfunction

	task automatic check_outputs();
		compare_value("flit_out_valid", exp_valid, flit_out_valid);
		compare_value("credit_out", exp_credit, credit_out);
		compare_value("ovc_allocated", exp_alloc, ovc_allocated);
		compare_value("ovc_released", exp_rel, ovc_released);
		if (exp_valid) begin // data only meaningful with valid
			compare_value("flit_out", exp_flit, flit_out);
			compare_value("port_out", exp_port, port_out);
			compare_value("ovc_out", exp_ovc, ovc_out);
		end
	endtask

	task automatic count_credits();
		for (int v = 0; v < VC_NUM; v++)
			if (credit_out[v])
				credits[v]++;
	endtask

	task automatic drive_upstream();
		int    v;
		flit_t f;
		v        = $urandom_range(VC_NUM - 1, 0);
		f        = '0;
		wr_in_en = 1'b0;
		flit_in  = '0;
		if (credits[v] == 0)
			return; // no buffer slot downstream
		if (left[v] == 0) begin // opening a new packet
			if (pkts_sent == NUM_PKTS || open_pkts[v] == PKT_DEPTH)
				return;
			f.hdr   = 1'b1;
			left[v] = $urandom_range(MAX_FLITS, 1);
			open_pkts[v]++;
			pkts_sent++;
		end
		f.pyld = $urandom();
		if (f.hdr)
			wr_port[v] = f.pyld[PORT_SEL_W-1:0]; // header low bits pick the port
		left[v]--;
		f.tail     = (left[v] == 0);
		f.vc       = vc_onehot_t'(1) << v;
		credits[v]--;
		flit_in    = f;
		wr_in_en   = 1'b1;
		pend_wr    = 1'b1;
		pend_vc    = v;
		pend_flit  = f;
		pend_port  = wr_port[v];
	endtask

	// allocator grants a random requester about half the time
	task automatic drive_grant();
		vc_onehot_t req;
		int         v;
		int         start;
		int         slot;
		req = model_request();
		compare_value("ivc_request", req, ivc_request);
		for (int q = 0; q < VC_NUM; q++)
			if (fq[q].size() != 0) // head packet's port toward the allocator
				compare_value("out_port_select", pq[q][0], out_port_select[q]);
		ivc_granted = '0;
		if (req == '0 || $urandom_range(1, 0) == 0)
			return;
		start = $urandom_range(VC_NUM - 1, 0);
		v     = start;
		for (int k = 0; k < VC_NUM; k++) begin
			v = (start + k) % VC_NUM;
			if (req[v])
				break;
		end
		ivc_granted[v] = 1'b1;
		exp_valid      = 1'b1;
		exp_flit       = fq[v].pop_front();
		exp_port       = pq[v].pop_front();
		exp_ovc        = assigned[v] ? held_ovc[v] : candidate_ovcs[exp_port];
		exp_credit[v]  = 1'b1;
		slot           = int'(exp_port) * VC_NUM + int'(exp_ovc);
		if (!assigned[v]) begin // header takes the offer of this cycle
			exp_alloc[slot] = 1'b1;
			assigned[v]     = 1'b1;
			held_ovc[v]     = exp_ovc;
		end
		if (exp_flit.tail) begin
			exp_rel[slot] = 1'b1;
			assigned[v]   = 1'b0;
			open_pkts[v]--;
		end
	endtask

	initial begin
		void'($urandom(32'h9073_b9ca));
		reset         = 1'b1;
		flit_in       = '0;
		wr_in_en      = 1'b0;
		ivc_granted   = '0;
		ovc_available = '0;
		for (int p = 0; p < PORT_SEL_NUM; p++)
			candidate_ovcs[p] = '0;
		for (int v = 0; v < VC_NUM; v++) begin
			assigned[v]  = 1'b0;
			held_ovc[v]  = '0;
			credits[v]   = BUF_DEPTH;
			open_pkts[v] = 0;
			left[v]      = 0;
			wr_port[v]   = '0;
		end
		{pkts_sent, errors, pend_vc} = '0;
		{exp_valid, exp_flit, exp_port, exp_ovc, exp_credit, exp_alloc, exp_rel} = '0;
		{pend_wr, pend_flit, pend_port} = '0;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;
		cycle = 16;
		repeat (2) @(posedge clk); // idle outputs after reset
		#1;
		compare_value("reset_idle flit_out_valid", 0, flit_out_valid);
		compare_value("reset_idle credit_out", 0, credit_out);
		compare_value("reset_idle ivc_request", 0, ivc_request);
		compare_value("reset_idle ovc_allocated", 0, ovc_allocated);
		compare_value("reset_idle ovc_released", 0, ovc_released);
		while (!traffic_drained() && cycle < LIMIT) begin
			@(posedge clk);
			#1;
			cycle++;
			wr_in_en    = 1'b0;
			ivc_granted = '0;
			check_outputs();
			count_credits();
			if (pend_wr) begin // now in the dut buffer
				fq[pend_vc].push_back(pend_flit);
				pq[pend_vc].push_back(pend_port);
				pend_wr = 1'b0;
			end
			{exp_valid, exp_credit, exp_alloc, exp_rel} = '0;
			ovc_available = PORT_SEL_NUM'($urandom());
			for (int p = 0; p < PORT_SEL_NUM; p++)
				candidate_ovcs[p] = vc_id_t'($urandom());
			drive_upstream();
			#1;
			drive_grant();
		end
		if (cycle >= LIMIT) begin
			$display("Timeout: traffic did not drain within %0d cycles", LIMIT);
			errors++;
		end else begin
			@(posedge clk); // outputs and credit of the last grant
			#1;
			cycle++;
			wr_in_en      = 1'b0;
			ivc_granted   = '0;
			ovc_available = '1; // any flit left behind would now request
			check_outputs();
			count_credits();
			#1;
			for (int v = 0; v < VC_NUM; v++)
				compare_value("end_credits", BUF_DEPTH, credits[v]);
			compare_value("end_buffer_empty", 0, ivc_request);
		end
		$display("Summary: %0d packets, %0d cycles, %0d errors", pkts_sent, cycle, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* all.f */
noc_pkg.sv
vc_fifo.sv
input_flit_buffer.sv
vc_route_state.sv
grant_output_stage.sv
input_port.sv
input_port_checker.sv
tb_input_port.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_input_port -f all.f &&
	./obj_dir/Vtb_input_port | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null &&
	echo "run.sh: simulation passed" ||
	{ echo "run.sh: simulation failed"; exit 1; }
